// ==== logic/u2_ctrl_pkg.sv ====
// Control plane shared definitions
`default_nettype none

package u2_ctrl_pkg;

   //////////////////////////////////////////////////
   // Settings bus
   localparam int SET_ADDR_W = 8;
   localparam int SET_DATA_W = 32;

   typedef logic [SET_ADDR_W-1:0] set_addr_t;
   typedef logic [SET_DATA_W-1:0] set_data_t;
   typedef logic [63:0]           vita_time_t;

   // Misc register block
   localparam set_addr_t SR_MISC    = 8'd0;
   localparam set_addr_t SR_SERDES  = SR_MISC + 8'd1;  // Serial link controls
   localparam set_addr_t SR_ADC     = SR_MISC + 8'd2;
   localparam set_addr_t SR_LED_SW  = SR_MISC + 8'd3;  // Software LED pattern
   localparam set_addr_t SR_PHY     = SR_MISC + 8'd4;
   localparam set_addr_t SR_LED_SRC = SR_MISC + 8'd6;  // 1 = hardware, 0 = software

   // Time load commits on the low word
   localparam set_addr_t SR_TIME_HI = 8'd10;
   localparam set_addr_t SR_TIME_LO = 8'd11;

   localparam int SER_CTRL_W = 4;
   localparam int ADC_CTRL_W = 4;
   localparam int LED_W      = 8;
   localparam logic [LED_W-1:0] LED_SRC_RESET = 8'h1E;

   //////////////////////////////////////////////////
   // Readback map
   localparam set_data_t COMPAT_NUM = {16'd10, 16'd0};  // Major, minor

   localparam int RB_ADDR_W = 4;
   localparam logic [RB_ADDR_W-1:0] RB_COMPAT  = 4'd0;
   localparam logic [RB_ADDR_W-1:0] RB_STATUS  = 4'd1;
   localparam logic [RB_ADDR_W-1:0] RB_TIME_HI = 4'd2;
   localparam logic [RB_ADDR_W-1:0] RB_TIME_LO = 4'd3;
   localparam logic [RB_ADDR_W-1:0] RB_PPS_HI  = 4'd4;
   localparam logic [RB_ADDR_W-1:0] RB_PPS_LO  = 4'd5;
   localparam set_data_t RB_UNUSED = 32'hFFFF_FFFF;

endpackage

`default_nettype wire

// ==== logic/settings_arbiter.sv ====
// Settings bus arbiter
`timescale 1ns/10ps
`default_nettype none

module settings_arbiter (
   input  logic                  dsp_clk,
   input  logic                  por_rst,
   input  logic                  host_stb_i,
   input  u2_ctrl_pkg::set_addr_t host_addr_i,
   input  u2_ctrl_pkg::set_data_t host_data_i,
   input  logic                  ctl_stb_i,
   input  u2_ctrl_pkg::set_addr_t ctl_addr_i,
   input  u2_ctrl_pkg::set_data_t ctl_data_i,
   output logic                  host_busy_o,
   output logic                  set_stb_o,
   output u2_ctrl_pkg::set_addr_t set_addr_o,
   output u2_ctrl_pkg::set_data_t set_data_o
);
   import u2_ctrl_pkg::*;

   logic      pend_valid;
   set_addr_t pend_addr;
   set_data_t pend_data;
   logic      take_pend;
   logic      take_host;
   logic      park_host;

   assign take_pend = !ctl_stb_i && pend_valid;
   assign take_host = !ctl_stb_i && !pend_valid && host_stb_i;
   assign park_host = ctl_stb_i && host_stb_i;   // Collision displaces the host write

   assign host_busy_o = pend_valid;

   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         set_stb_o  <= 1'b0;
         pend_valid <= 1'b0;
      end else begin
         set_stb_o <= ctl_stb_i | take_pend | take_host;
         if (park_host) begin
            pend_valid <= 1'b1;
         end else if (take_pend) begin
            pend_valid <= 1'b0;
         end
      end
   end

   // Merged payload and held host write
   always_ff @(posedge dsp_clk) begin
      if (ctl_stb_i) begin
         set_addr_o <= ctl_addr_i;
         set_data_o <= ctl_data_i;
      end else if (take_pend) begin
         set_addr_o <= pend_addr;
         set_data_o <= pend_data;
      end else if (take_host) begin
         set_addr_o <= host_addr_i;
         set_data_o <= host_data_i;
      end
      if (park_host) begin
         pend_addr <= host_addr_i;
         pend_data <= host_data_i;
      end
   end

   // The one-entry slot takes no new host write while full
   a_host_no_stb_when_busy : assert property (
      @(posedge dsp_clk) disable iff (por_rst) !(host_stb_i && host_busy_o));

endmodule

`default_nettype wire

// ==== logic/misc_regs.sv ====
// Miscellaneous setting registers
// Serial link, ADC, PHY reset and LED source select
`timescale 1ns/10ps
`default_nettype none

module misc_regs (
   input  logic                  dsp_clk,
   input  logic                  por_rst,
   input  logic                  set_stb_i,
   input  u2_ctrl_pkg::set_addr_t set_addr_i,
   input  u2_ctrl_pkg::set_data_t set_data_i,
   input  logic                  run_rx_i,
   input  logic                  run_tx_i,
   input  logic                  clk_status_i,
   input  logic                  link_up_i,
   input  logic                  good_sync_i,
   output logic [u2_ctrl_pkg::SER_CTRL_W-1:0] ser_ctrl_o,
   output logic [u2_ctrl_pkg::ADC_CTRL_W-1:0] adc_ctrl_o,
   output logic                  phy_reset_n_o,
   output logic [u2_ctrl_pkg::LED_W-1:0]      leds_o
);
   import u2_ctrl_pkg::*;

   logic             phy_reset;
   logic [LED_W-1:0] led_sw;
   logic [LED_W-1:0] led_src;
   logic [LED_W-1:0] led_hw;

   //////////////////////////////////////////////////
   // Register decode
   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         ser_ctrl_o <= '0;
         adc_ctrl_o <= '0;
         led_sw     <= '0;
         phy_reset  <= 1'b0;
         led_src    <= LED_SRC_RESET;   // Status LEDs under hardware control
      end else if (set_stb_i) begin
         case (set_addr_i)
            SR_SERDES:  ser_ctrl_o <= set_data_i[SER_CTRL_W-1:0];
            SR_ADC:     adc_ctrl_o <= set_data_i[ADC_CTRL_W-1:0];
            SR_LED_SW:  led_sw     <= set_data_i[LED_W-1:0];
            SR_PHY:     phy_reset  <= set_data_i[0];
            SR_LED_SRC: led_src    <= set_data_i[LED_W-1:0];
            default: ;
         endcase
      end
   end

   assign phy_reset_n_o = ~phy_reset;

   //////////////////////////////////////////////////
   // LED mux

   // Activity and link indicators
   assign led_hw = {3'b000,
                    run_tx_i,
                    run_rx_i,
                    clk_status_i,
                    link_up_i & good_sync_i,
                    1'b0};

   // Per bit select between hardware and software
   assign leds_o = (led_src & led_hw) | (~led_src & led_sw);

endmodule

`default_nettype wire

// ==== logic/vita_time_counter.sv ====
// VITA 64-bit time counter
// Software load and PPS capture
`timescale 1ns/10ps
`default_nettype none

module vita_time_counter (
   input  logic                  dsp_clk,
   input  logic                  por_rst,
   input  logic                  set_stb_i,
   input  u2_ctrl_pkg::set_addr_t set_addr_i,
   input  u2_ctrl_pkg::set_data_t set_data_i,
   input  logic                  pps_i,
   output u2_ctrl_pkg::vita_time_t vita_time_o,
   output u2_ctrl_pkg::vita_time_t vita_time_pps_o,
   output logic                  pps_int_o
);
   import u2_ctrl_pkg::*;

   set_data_t time_hi_hold;
   logic      pps_meta;
   logic      pps_sync;
   logic      pps_sync_d;
   logic      pps_edge;
   logic      load_lo;

   assign load_lo  = set_stb_i && (set_addr_i == SR_TIME_LO);
   assign pps_edge = pps_sync && !pps_sync_d;   // Rising edge only

   //////////////////////////////////////////////////
   // PPS synchronizer
   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         pps_meta   <= 1'b0;
         pps_sync   <= 1'b0;
         pps_sync_d <= 1'b0;
      end else begin
         pps_meta   <= pps_i;
         pps_sync   <= pps_meta;
         pps_sync_d <= pps_sync;
      end
   end

   //////////////////////////////////////////////////
   // Time and capture
   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         time_hi_hold    <= '0;
         vita_time_o     <= '0;
         vita_time_pps_o <= '0;
         pps_int_o       <= 1'b0;
      end else begin
         if (set_stb_i && (set_addr_i == SR_TIME_HI)) begin
            time_hi_hold <= set_data_i;   // Waits for low word
         end
         if (load_lo) begin
            vita_time_o <= {time_hi_hold, set_data_i};
         end else begin
            vita_time_o <= vita_time_o + 64'd1;
         end
         if (pps_edge) begin
            vita_time_pps_o <= vita_time_o;
         end
         pps_int_o <= pps_edge;
      end
   end

   // Settings writes carry a known address
   a_set_addr_known : assert property (
      @(posedge dsp_clk) disable iff (por_rst) set_stb_i |-> !$isunknown(set_addr_i));

endmodule

`default_nettype wire

// ==== logic/readback_mux.sv ====
// Readback word selector
`timescale 1ns/10ps
`default_nettype none

module readback_mux (
   input  logic                               dsp_clk,
   input  logic                               por_rst,
   input  logic [u2_ctrl_pkg::RB_ADDR_W-1:0]  rb_addr_i,
   input  u2_ctrl_pkg::vita_time_t            vita_time_i,
   input  u2_ctrl_pkg::vita_time_t            vita_time_pps_i,
   input  logic                               button_i,
   input  logic                               clk_status_i,
   input  logic                               link_up_i,
   output u2_ctrl_pkg::set_data_t             rb_data_o
);
   import u2_ctrl_pkg::*;

   set_data_t status_word;

   // Button at 13, clock status at 11, link at 10
   assign status_word = {18'd0, button_i, 1'b0, clk_status_i, link_up_i, 10'd0};

   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         rb_data_o <= '0;
      end else begin
         case (rb_addr_i)
            RB_COMPAT:  rb_data_o <= COMPAT_NUM;
            RB_STATUS:  rb_data_o <= status_word;
            RB_TIME_HI: rb_data_o <= vita_time_i[63:32];
            RB_TIME_LO: rb_data_o <= vita_time_i[31:0];
            RB_PPS_HI:  rb_data_o <= vita_time_pps_i[63:32];
            RB_PPS_LO:  rb_data_o <= vita_time_pps_i[31:0];
            default:    rb_data_o <= RB_UNUSED;   // Unmapped
         endcase
      end
   end

endmodule

`default_nettype wire

// ==== logic/u2_control_core.sv ====
// Radio control plane top level
// Settings arbiter, misc registers, VITA time and readback
`timescale 1ns/10ps
`default_nettype none

module u2_control_core (
   input  logic                               dsp_clk,
   input  logic                               por_rst,
   // Host settings writes
   input  logic                               host_stb_i,
   input  u2_ctrl_pkg::set_addr_t             host_addr_i,
   input  u2_ctrl_pkg::set_data_t             host_data_i,
   output logic                               host_busy_o,
   // Packet control settings writes
   input  logic                               ctl_stb_i,
   input  u2_ctrl_pkg::set_addr_t             ctl_addr_i,
   input  u2_ctrl_pkg::set_data_t             ctl_data_i,
   // Timing
   input  logic                               pps_i,
   output logic                               pps_int_o,
   // Status inputs
   input  logic                               run_rx_i,
   input  logic                               run_tx_i,
   input  logic                               clk_status_i,
   input  logic                               link_up_i,
   input  logic                               good_sync_i,
   input  logic                               button_i,
   // Readback
   input  logic [u2_ctrl_pkg::RB_ADDR_W-1:0]  rb_addr_i,
   output u2_ctrl_pkg::set_data_t             rb_data_o,
   // Control lines
   output logic [u2_ctrl_pkg::SER_CTRL_W-1:0] ser_ctrl_o,
   output logic [u2_ctrl_pkg::ADC_CTRL_W-1:0] adc_ctrl_o,
   output logic                               phy_reset_n_o,
   output logic [u2_ctrl_pkg::LED_W-1:0]      leds_o
);
   import u2_ctrl_pkg::*;

   logic       set_stb;
   set_addr_t  set_addr;
   set_data_t  set_data;
   vita_time_t vita_time;
   vita_time_t vita_time_pps;

   //////////////////////////////////////////////////
   // Settings bus
   settings_arbiter i_settings_arbiter (
      .dsp_clk(dsp_clk), .por_rst(por_rst),
      .host_stb_i(host_stb_i), .host_addr_i(host_addr_i), .host_data_i(host_data_i),
      .ctl_stb_i(ctl_stb_i), .ctl_addr_i(ctl_addr_i), .ctl_data_i(ctl_data_i),
      .host_busy_o(host_busy_o),
      .set_stb_o(set_stb), .set_addr_o(set_addr), .set_data_o(set_data)
   );

   //////////////////////////////////////////////////
   // Setting consumers
   misc_regs i_misc_regs (
      .dsp_clk(dsp_clk), .por_rst(por_rst),
      .set_stb_i(set_stb), .set_addr_i(set_addr), .set_data_i(set_data),
      .run_rx_i(run_rx_i), .run_tx_i(run_tx_i),
      .clk_status_i(clk_status_i), .link_up_i(link_up_i), .good_sync_i(good_sync_i),
      .ser_ctrl_o(ser_ctrl_o), .adc_ctrl_o(adc_ctrl_o),
      .phy_reset_n_o(phy_reset_n_o), .leds_o(leds_o)
   );

   vita_time_counter i_vita_time_counter (
      .dsp_clk(dsp_clk), .por_rst(por_rst),
      .set_stb_i(set_stb), .set_addr_i(set_addr), .set_data_i(set_data),
      .pps_i(pps_i),
      .vita_time_o(vita_time), .vita_time_pps_o(vita_time_pps),
      .pps_int_o(pps_int_o)
   );

   //////////////////////////////////////////////////
   // Readback
   readback_mux i_readback_mux (
      .dsp_clk(dsp_clk), .por_rst(por_rst),
      .rb_addr_i(rb_addr_i),
      .vita_time_i(vita_time), .vita_time_pps_i(vita_time_pps),
      .button_i(button_i), .clk_status_i(clk_status_i), .link_up_i(link_up_i),
      .rb_data_o(rb_data_o)
   );

endmodule

`default_nettype wire

// ==== include/tb_ref_model.svh ====
// Control core reference model
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

// Hardware bit where the LED source bit is set
function automatic logic [7:0] led_ref(input logic [7:0] src, input logic [7:0] sw,
                                       input logic rx, input logic tx, input logic clk_ok,
                                       input logic link, input logic sync);
   logic [7:0] hw;
   logic [7:0] r;
   int         i;
   hw = {3'b000, tx, rx, clk_ok, link & sync, 1'b0};
   for (i = 0; i < 8; i++) begin
      r[i] = src[i] ? hw[i] : sw[i];
   end
   return r;
endfunction

function automatic logic [31:0] status_ref(input logic button, input logic clk_ok,
                                           input logic link);
   logic [31:0] s;
   s     = 32'h0;
   s[13] = button;
   s[11] = clk_ok;
   s[10] = link;
   return s;
endfunction

task automatic apply_write(input logic [7:0] addr, input logic [31:0] data);
   case (addr)
      SR_SERDES:  exp_ser = data[3:0];
      SR_ADC:     exp_adc = data[3:0];
      SR_LED_SW:  exp_sw  = data[7:0];
      SR_PHY:     exp_phy = data[0];
      SR_LED_SRC: exp_src = data[7:0];
      default: ;
   endcase
endtask

// Host writes queue up behind control writes on a one-stage bus
task automatic arb_step();
   if (por_rst) begin
      host_q.delete();
      bus_stb  = 1'b0;
      exp_busy = 1'b0;
      exp_ser  = '0;
      exp_adc  = '0;
      exp_phy  = 1'b0;
      exp_sw   = '0;
      exp_src  = 8'h1E;
   end else begin
      if (bus_stb) begin
         apply_write(bus_addr, bus_data);   // Register lands one cycle after bus
      end
      if (host_stb_i) begin
         host_q.push_back({host_addr_i, host_data_i});
      end
      bus_stb = ctl_stb_i || (host_q.size() != 0);
      if (ctl_stb_i) begin
         bus_addr = ctl_addr_i;
         bus_data = ctl_data_i;
      end else if (host_q.size() != 0) begin
         {bus_addr, bus_data} = host_q.pop_front();
      end
      exp_busy = (host_q.size() != 0);
   end
endtask

task automatic check_eq(input logic [63:0] expected, input logic [63:0] actual,
                        input string what);
   if (actual !== expected) begin
      $display("MISMATCH at %0t: %s expected %0h got %0h", $time, what, expected, actual);
      $display("TEST FAILED");
      $fatal(1, "%s mismatch", what);
   end
endtask

`endif

// ==== testbench/tb_u2_control_core.sv ====
// Control core testbench
`timescale 1ns/10ps
`default_nettype none

module tb_u2_control_core;
   import u2_ctrl_pkg::*;

   logic                  dsp_clk = 1'b0;
   logic                  por_rst;
   logic                  host_stb_i;
   set_addr_t             host_addr_i;
   set_data_t             host_data_i;
   logic                  host_busy_o;
   logic                  ctl_stb_i;
   set_addr_t             ctl_addr_i;
   set_data_t             ctl_data_i;
   logic                  pps_i;
   logic                  pps_int_o;
   logic                  run_rx_i;
   logic                  run_tx_i;
   logic                  clk_status_i;
   logic                  link_up_i;
   logic                  good_sync_i;
   logic                  button_i;
   logic [RB_ADDR_W-1:0]  rb_addr_i;
   set_data_t             rb_data_o;
   logic [SER_CTRL_W-1:0] ser_ctrl_o;
   logic [ADC_CTRL_W-1:0] adc_ctrl_o;
   logic                  phy_reset_n_o;
   logic [LED_W-1:0]      leds_o;

   // Reference state
   logic        bus_stb;
   logic [7:0]  bus_addr;
   logic [31:0] bus_data;
   logic [39:0] host_q[$];   // Address and data of waiting host writes
   logic        exp_busy;
   logic [3:0]  exp_ser;
   logic [3:0]  exp_adc;
   logic        exp_phy;
   logic [7:0]  exp_sw;
   logic [7:0]  exp_src;
   logic [15:0] lfsr = 16'd76;

   `include "tb_ref_model.svh"

   u2_control_core i_u2_control_core (.*);

   always #2 dsp_clk = ~dsp_clk;

   always @(posedge dsp_clk) begin
      arb_step();
   end

   //////////////////////////////////////////////////
   // Compare outputs against the model every cycle
   always @(negedge dsp_clk) begin
      if (!por_rst) begin
         check_eq(64'(exp_ser), 64'(ser_ctrl_o), "ser_ctrl_o");
         check_eq(64'(exp_adc), 64'(adc_ctrl_o), "adc_ctrl_o");
         check_eq(64'(!exp_phy), 64'(phy_reset_n_o), "phy_reset_n_o");
         check_eq(64'(exp_busy), 64'(host_busy_o), "host_busy_o");
         check_eq(64'(led_ref(exp_src, exp_sw, run_rx_i, run_tx_i, clk_status_i,
                              link_up_i, good_sync_i)), 64'(leds_o), "leds_o");
      end
   end

   //////////////////////////////////////////////////
   // Stimulus helpers

   // Galois LFSR stepped once per bit
   function automatic logic rand_bit();
      logic b;
      b    = lfsr[0];
      lfsr = {1'b0, lfsr[15:1]} ^ (lfsr[0] ? 16'hB400 : 16'h0000);
      return b;
   endfunction

   function automatic logic [31:0] rand_word(input int n);
      logic [31:0] w;
      int          i;
      w = '0;
      for (i = 0; i < n; i++) begin
         w = {w[30:0], rand_bit()};
      end
      return w;
   endfunction

   task automatic host_write(input set_addr_t addr, input set_data_t data);
      @(posedge dsp_clk);
      host_stb_i  <= 1'b1;
      host_addr_i <= addr;
      host_data_i <= data;
      @(posedge dsp_clk);
      host_stb_i  <= 1'b0;
   endtask

   task automatic read_rb(input logic [RB_ADDR_W-1:0] addr, output set_data_t data);
      @(posedge dsp_clk);
      rb_addr_i <= addr;
      @(posedge dsp_clk);   // Address captured here
      @(negedge dsp_clk);
      data = rb_data_o;
   endtask

   task automatic wait_busy(input logic level);
      int cycles;
      cycles = 0;
      do begin
         @(negedge dsp_clk);
         cycles++;
      end while (host_busy_o !== level && cycles < 64);
      if (host_busy_o !== level) begin
         $display("Timeout: host_busy_o never reached %0b", level);
         $display("TEST FAILED");
         $fatal(1, "host busy wait timed out");
      end
   endtask

   //////////////////////////////////////////////////
   // Main sequence
   initial begin
      set_data_t rd;
      set_data_t hi;
      set_data_t lo;
      set_data_t lo_before;
      set_data_t lo_after;
      set_data_t pps_lo;
      set_data_t host_val;
      set_addr_t addr;
      int        cycles;
      int        a;

      por_rst      <= 1'b1;
      host_stb_i   <= 1'b0;
      host_addr_i  <= '0;
      host_data_i  <= '0;
      ctl_stb_i    <= 1'b0;
      ctl_addr_i   <= '0;
      ctl_data_i   <= '0;
      pps_i        <= 1'b0;
      run_rx_i     <= 1'b1;   // Hardware pattern 0x1E shows the reset LED source
      run_tx_i     <= 1'b1;
      clk_status_i <= 1'b1;
      link_up_i    <= 1'b1;
      good_sync_i  <= 1'b1;
      button_i     <= 1'b0;
      rb_addr_i    <= '0;
      repeat (5) @(posedge dsp_clk);
      por_rst <= 1'b0;
      @(negedge dsp_clk);
      check_eq(64'd1, 64'(phy_reset_n_o), "phy_reset_n_o after reset");

      // Control line writes
      repeat (12) begin
         case (rand_word(2))
            32'd0:   addr = SR_SERDES;
            32'd1:   addr = SR_ADC;
            default: addr = SR_PHY;
         endcase
         host_write(addr, rand_word(32));
      end

      // LED source mux with random status inputs
      repeat (8) begin
         @(posedge dsp_clk);
         run_rx_i     <= rand_bit();
         run_tx_i     <= rand_bit();
         clk_status_i <= rand_bit();
         link_up_i    <= rand_bit();
         good_sync_i  <= rand_bit();
         host_write(SR_LED_SRC, rand_word(8));
         host_write(SR_LED_SW, rand_word(8));
      end

      // Collision on SR_ADC while control keeps the bus a few more cycles
      host_val = rand_word(32);
      @(posedge dsp_clk);
      ctl_stb_i   <= 1'b1;
      ctl_addr_i  <= SR_ADC;
      ctl_data_i  <= rand_word(32);
      host_stb_i  <= 1'b1;
      host_addr_i <= SR_ADC;
      host_data_i <= host_val;
      @(posedge dsp_clk);
      host_stb_i <= 1'b0;
      ctl_addr_i <= SR_SERDES;
      wait_busy(1'b1);
      repeat (3) begin
         @(posedge dsp_clk);
         ctl_data_i <= rand_word(32);
      end
      @(posedge dsp_clk);
      ctl_stb_i <= 1'b0;
      wait_busy(1'b0);
      @(negedge dsp_clk);
      check_eq(64'(host_val[3:0]), 64'(adc_ctrl_o), "adc_ctrl_o after held host write");

      // Time load, then PPS capture
      hi = rand_word(32);
      lo = rand_word(28);   // Keeps the carry out of the high word
      host_write(SR_TIME_HI, hi);
      host_write(SR_TIME_LO, lo);
      read_rb(RB_TIME_HI, rd);
      check_eq(64'(hi), 64'(rd), "time high word");
      read_rb(RB_TIME_LO, lo_before);
      @(posedge dsp_clk);
      pps_i  <= 1'b1;
      cycles = 0;
      do begin
         @(negedge dsp_clk);
         cycles++;
      end while (pps_int_o !== 1'b1 && cycles < 16);
      if (pps_int_o !== 1'b1) begin
         $display("Timeout: no PPS interrupt after the PPS input rose");
         $display("TEST FAILED");
         $fatal(1, "PPS wait timed out");
      end
      @(negedge dsp_clk);
      check_eq(64'd0, 64'(pps_int_o), "pps_int_o second cycle");
      @(posedge dsp_clk);
      pps_i <= 1'b0;
      read_rb(RB_TIME_LO, lo_after);
      read_rb(RB_PPS_HI, rd);
      check_eq(64'(hi), 64'(rd), "PPS time high word");
      read_rb(RB_PPS_LO, pps_lo);
      check_eq(64'd1, 64'(pps_lo >= lo_before && pps_lo <= lo_after), "PPS low word range");

      // Readback map
      @(posedge dsp_clk);
      button_i     <= rand_bit();
      clk_status_i <= rand_bit();
      link_up_i    <= rand_bit();
      read_rb(RB_COMPAT, rd);
      check_eq(64'({16'd10, 16'd0}), 64'(rd), "compatibility word");
      read_rb(RB_STATUS, rd);
      check_eq(64'(status_ref(button_i, clk_status_i, link_up_i)), 64'(rd), "status word");
      for (a = 6; a < 16; a++) begin
         read_rb(4'(a), rd);
         check_eq(64'hFFFF_FFFF, 64'(rd), "unmapped readback");
      end

      $display("TEST OK");
      $finish;
   end

endmodule

`default_nettype wire

// ==== sources.f ====
+incdir+include
logic/u2_ctrl_pkg.sv
logic/settings_arbiter.sv
logic/misc_regs.sv
logic/vita_time_counter.sv
logic/readback_mux.sv
logic/u2_control_core.sv
testbench/tb_u2_control_core.sv

// ==== Makefile ====
# Verilator build and run for the control core testbench

VERILATOR ?= verilator
FILELIST  ?= sources.f
TB_TOP    ?= tb_u2_control_core
RTL_TOP   ?= u2_control_core
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert
SIM       := $(OBJ_DIR)/V$(TB_TOP)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) --Mdir $(OBJ_DIR)

run: build
	./$(SIM)

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(OBJ_DIR)
